//--- Bender.yml
package:
  name: apb_div

sources:
  - files:
      - div_pkg.sv
      - apb_div_regs.sv
      - div_ctrl.sv
      - div_dpath.sv
      - div_result_stage.sv
      - apb_div_top.sv
  - target: test
    files:
      - apb_div_props.sv
      - tb_apb_div.sv

//--- apb_div_props.sv
/*
  bound checker for the APB divide unit
  bus response rules and status consistency
*/

`timescale 1ns/100ps

module apb_div_props (
  input logic              clk,
  input logic              reset,
  input div_pkg::apb_req_t apb_req,
  input div_pkg::apb_rsp_t apb_rsp,
  input logic              busy,
  input logic              done
);

  // failures so far, read by the testbench at the end
  int fail_count = 0;

  // zero wait state slave
  pready_high: assert property (@(posedge clk) disable iff (reset) apb_rsp.pready)
    else begin
      $error("pready went low");
      fail_count++;
    end

  // a division is either running or finished
  busy_done_excl: assert property (@(posedge clk) disable iff (reset) !(busy && done))
    else begin
      $error("busy and done both high");
      fail_count++;
    end

  // slave error only in the access phase
  slverr_in_access: assert property (@(posedge clk) disable iff (reset)
    apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
    else begin
      $error("pslverr outside an access cycle");
      fail_count++;
    end

endmodule

bind apb_div_top apb_div_props props_i (
  .clk     (clk),
  .reset   (reset),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .busy    (busy),
  .done    (done)
);

//--- apb_div_regs.sv
/*
  APB slave register block of the divide unit
  holds operands and mode, launches a division, serves status and results
*/

`timescale 1ns/100ps

module apb_div_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  div_pkg::apb_req_t    apb_req,
  output div_pkg::apb_rsp_t    apb_rsp,
  input  logic                 busy,
  input  logic                 done,
  input  div_pkg::div_result_t result,
  output logic                 start,
  output div_pkg::div_req_t    req
);

  // software visible registers
  logic [div_pkg::data_w-1:0] operand_a;
  logic [div_pkg::data_w-1:0] operand_b;
  logic                       is_signed_q;

  // decode
  logic access;
  logic hit_a;
  logic hit_b;
  logic hit_ctrl;
  logic hit_status;
  logic hit_quot;
  logic hit_rem;
  logic mapped;
  logic read_only;
  logic start_req;
  logic slv_err;
  logic wr_ok;

  logic [div_pkg::data_w-1:0] rdata;

  // ----------------------------------------
  // address decode and error checks
  // ----------------------------------------

  // access phase of a transfer
  assign access = apb_req.psel & apb_req.penable;

  assign hit_a      = apb_req.paddr == div_pkg::reg_operand_a;
  assign hit_b      = apb_req.paddr == div_pkg::reg_operand_b;
  assign hit_ctrl   = apb_req.paddr == div_pkg::reg_ctrl;
  assign hit_status = apb_req.paddr == div_pkg::reg_status;
  assign hit_quot   = apb_req.paddr == div_pkg::reg_quotient;
  assign hit_rem    = apb_req.paddr == div_pkg::reg_remainder;

  assign mapped    = hit_a | hit_b | hit_ctrl | hit_status | hit_quot | hit_rem;
  assign read_only = hit_status | hit_quot | hit_rem;

  // ctrl write with the start bit set
  assign start_req = hit_ctrl & apb_req.pwrite & apb_req.pwdata[div_pkg::ctrl_start_bit];

  // unmapped, write to read-only, or start while a division runs
  assign slv_err = access & (~mapped | (apb_req.pwrite & read_only) | (start_req & busy));

  // only error-free writes touch state
  assign wr_ok = access & apb_req.pwrite & ~slv_err;

  // single cycle launch pulse, never while busy
  assign start = wr_ok & start_req;

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      operand_a   <= '0;
      operand_b   <= '0;
      is_signed_q <= 1'b0;
    end else if (wr_ok) begin
      if (hit_a) begin
        operand_a <= apb_req.pwdata;
      end
      if (hit_b) begin
        operand_b <= apb_req.pwdata;
      end
      // signed mode updates on any ctrl write, start or not
      if (hit_ctrl) begin
        is_signed_q <= apb_req.pwdata[div_pkg::ctrl_signed_bit];
      end
    end
  end

  // request snapshot taken with the start pulse
  // mode comes from the same ctrl write that launches
  always_ff @(posedge clk) begin
    if (start) begin
      req.a         <= operand_a;
      req.b         <= operand_b;
      req.is_signed <= apb_req.pwdata[div_pkg::ctrl_signed_bit];
    end
  end

  // ----------------------------------------
  // read mux
  // ----------------------------------------

  always_comb begin
    rdata = '0;
    case (apb_req.paddr)
      div_pkg::reg_operand_a: rdata = operand_a;
      div_pkg::reg_operand_b: rdata = operand_b;
      // start bit is write only and reads as 0
      div_pkg::reg_ctrl: rdata[div_pkg::ctrl_signed_bit] = is_signed_q;
      div_pkg::reg_status: begin
        rdata[div_pkg::status_busy_bit] = busy;
        rdata[div_pkg::status_done_bit] = done;
        rdata[div_pkg::status_zero_bit] = result.by_zero;
      end
      div_pkg::reg_quotient:  rdata = result.quot;
      div_pkg::reg_remainder: rdata = result.rem;
      default: rdata = '0;
    endcase
  end

  // zero wait state slave
  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = slv_err;

endmodule

//--- apb_div_top.sv
/*
  APB divide unit top level
  register block, control FSM, datapath and result stage
*/

`timescale 1ns/100ps

module apb_div_top (
  input  logic              clk,
  input  logic              reset,
  input  div_pkg::apb_req_t apb_req,
  output div_pkg::apb_rsp_t apb_rsp
);

  // launch and status
  logic start;
  logic busy;
  logic done;

  // datapath sequencing
  logic load_en;
  logic step_en;
  logic mag_valid;

  div_pkg::div_req_t    req;
  div_pkg::div_mag_t    mag;
  div_pkg::div_result_t result;

  apb_div_regs regs_i (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .busy    (busy),
    .done    (done),
    .result  (result),
    .start   (start),
    .req     (req)
  );

  div_ctrl ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .load_en   (load_en),
    .step_en   (step_en),
    .mag_valid (mag_valid)
  );

  div_dpath dpath_i (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .load_en (load_en),
    .step_en (step_en),
    .mag     (mag)
  );

  div_result_stage result_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .mag_valid (mag_valid),
    .mag       (mag),
    .result    (result),
    .busy      (busy),
    .done      (done)
  );

endmodule

//--- div_ctrl.sv
/*
  divider control FSM
  sequences one load cycle, one step per quotient bit, then a valid pulse
*/

`timescale 1ns/100ps

module div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic load_en,
  output logic step_en,
  output logic mag_valid
);

  // one step per quotient bit
  localparam int cnt_w = $clog2(div_pkg::data_w);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(div_pkg::data_w - 1);

  // state encoding
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_load = 2'd1;
  localparam logic [1:0] st_calc = 2'd2;

  logic [1:0]       state;
  logic [cnt_w-1:0] step_cnt;
  logic             last_step;

  // final shift/subtract cycle
  assign last_step = (state == st_calc) && (step_cnt == last_cnt);

  // ----------------------------------------
  // state and counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      step_cnt  <= '0;
      mag_valid <= 1'b0;
    end else begin
      // pulse lands in the cycle after the last step
      mag_valid <= last_step;
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_load;
          end
        end
        st_load: begin
          state    <= st_calc;
          step_cnt <= '0;
        end
        st_calc: begin
          // counter wraps to 0 on the last step
          step_cnt <= step_cnt + 1'b1;
          if (last_step) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // datapath enables decoded from state
  assign load_en = (state == st_load);
  assign step_en = (state == st_calc);

endmodule

//--- div_dpath.sv
/*
  restoring divider datapath
  operand magnitudes in, one quotient bit per step, signs recorded on load
*/

`timescale 1ns/100ps

module div_dpath (
  input  logic               clk,
  input  logic               reset,
  input  div_pkg::div_req_t  req,
  input  logic               load_en,
  input  logic               step_en,
  output div_pkg::div_mag_t  mag
);

  localparam int w = div_pkg::data_w;

  // operand signs, only meaningful in signed mode
  logic a_neg;
  logic b_neg;

  // operand magnitudes
  logic [w-1:0] a_mag;
  logic [w-1:0] b_mag;

  // divisor magnitude held for the whole run
  logic [w-1:0] divisor;

  // remainder in the upper half, quotient filling in from bit 0
  logic [2*w:0] acc;
  logic [2*w:0] shifted;
  logic [2*w:0] diff;

  // sign and zero records
  logic quot_neg_q;
  logic rem_neg_q;
  logic by_zero_q;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  assign a_neg = req.is_signed & req.a[w-1];
  assign b_neg = req.is_signed & req.b[w-1];

  // two's complement negate, most negative value maps to itself as unsigned
  assign a_mag = a_neg ? -req.a : req.a;
  assign b_mag = b_neg ? -req.b : req.b;

  // ----------------------------------------
  // shift and subtract
  // ----------------------------------------

  assign shifted = acc << 1;
  // divisor aligned with the remainder half
  assign diff = shifted - {1'b0, divisor, {w{1'b0}}};

  always_ff @(posedge clk) begin
    if (load_en) begin
      acc     <= {{(w + 1){1'b0}}, a_mag};
      divisor <= b_mag;
    end else if (step_en) begin
      // negative difference, restore and shift in a 0
      if (diff[2*w]) begin
        acc <= shifted;
      end else begin
        acc <= {diff[2*w:1], 1'b1};
      end
    end
  end

  // ----------------------------------------
  // sign and zero divisor records
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg_q <= 1'b0;
      rem_neg_q  <= 1'b0;
      by_zero_q  <= 1'b0;
    end else if (load_en) begin
      quot_neg_q <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg_q  <= a_neg;
      by_zero_q  <= (req.b == '0);
    end
  end

  // outcome is presented continuously, valid once the steps finish
  assign mag.quot_mag = acc[w-1:0];
  assign mag.rem_mag  = acc[2*w-1:w];
  assign mag.quot_neg = quot_neg_q;
  assign mag.rem_neg  = rem_neg_q;
  assign mag.by_zero  = by_zero_q;

endmodule

//--- div_pkg.sv
/*
  shared definitions for the APB divide unit
  bus structs, divider request/result structs and the register map
*/

package div_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // operand width follows the APB data word
  localparam int data_w = 32;
  // register offsets fit in one byte
  localparam int addr_w = 8;

  // ----------------------------------------
  // bus and divider structs
  // ----------------------------------------

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // operands as written by software, plus the signed mode
  typedef struct packed {
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic              is_signed;
  } div_req_t;

  // raw datapath outcome, magnitudes and the signs to apply
  typedef struct packed {
    logic [data_w-1:0] quot_mag;
    logic [data_w-1:0] rem_mag;
    logic              quot_neg;
    logic              rem_neg;
    logic              by_zero;
  } div_mag_t;

  typedef struct packed {
    logic [data_w-1:0] quot;
    logic [data_w-1:0] rem;
    logic              by_zero;
  } div_result_t;

  // ----------------------------------------
  // register map
  // ----------------------------------------

  localparam logic [addr_w-1:0] reg_operand_a = 8'h00;
  localparam logic [addr_w-1:0] reg_operand_b = 8'h04;
  localparam logic [addr_w-1:0] reg_ctrl      = 8'h08;
  localparam logic [addr_w-1:0] reg_status    = 8'h0C;
  localparam logic [addr_w-1:0] reg_quotient  = 8'h10;
  localparam logic [addr_w-1:0] reg_remainder = 8'h14;

  // ctrl word bits
  localparam int ctrl_start_bit  = 0;
  localparam int ctrl_signed_bit = 1;

  // status word bits
  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;
  localparam int status_zero_bit = 2;

endpackage

//--- div_result_stage.sv
/*
  divider result stage
  sign fix-up, zero divisor override, held result and busy/done status
*/

`timescale 1ns/100ps

module div_result_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 mag_valid,
  input  div_pkg::div_mag_t    mag,
  output div_pkg::div_result_t result,
  output logic                 busy,
  output logic                 done
);

  logic [div_pkg::data_w-1:0] quot_fix;
  logic [div_pkg::data_w-1:0] rem_fix;
  div_pkg::div_result_t       next_result;

  // ----------------------------------------
  // sign fix-up and override
  // ----------------------------------------

  assign quot_fix = mag.quot_neg ? -mag.quot_mag : mag.quot_mag;
  assign rem_fix  = mag.rem_neg ? -mag.rem_mag : mag.rem_mag;

  always_comb begin
    // zero divisor gives an all ones quotient
    next_result.quot = mag.by_zero ? '1 : quot_fix;
    // with b = 0 every step subtracts nothing, so the remainder half
    // ends as |a| and the fix-up above turns it back into operand a
    next_result.rem     = rem_fix;
    next_result.by_zero = mag.by_zero;
  end

  // ----------------------------------------
  // result hold and status
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      busy   <= 1'b0;
      done   <= 1'b0;
    end else begin
      // held until the next capture
      if (mag_valid) begin
        result <= next_result;
      end
      // start never meets mag_valid, the slave rejects it while busy
      if (start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (mag_valid) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

endmodule

//--- sim.f
div_pkg.sv
apb_div_regs.sv
div_ctrl.sv
div_dpath.sv
div_result_stage.sv
apb_div_top.sv
apb_div_props.sv
tb_apb_div.sv

//--- tb_apb_div.sv
/*
  testbench for the APB divide unit
  register access, random divisions against a reference model, status timing
*/

`timescale 1ns/100ps

module tb_apb_div;

  // 200 operations of about 50 cycles each, doubled
  localparam int max_cycles = 20000;
  localparam int num_ops    = 200;

  logic              clk = 1'b0;
  logic              reset;
  div_pkg::apb_req_t apb_req;
  div_pkg::apb_rsp_t apb_rsp;

  int unsigned cycles    = 0;
  logic [31:0] lcg_state = 32'd62;

  apb_div_top dut_i (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ----------------------------------------
  // run limit and failure exit
  // ----------------------------------------

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout, tests did not finish within %0d cycles", max_cycles);
      abort_run();
    end
  end

  // ----------------------------------------
  // random numbers and reference model
  // ----------------------------------------

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // truncating division, remainder follows the sign of a
  function automatic div_pkg::div_result_t model_div(input logic [31:0] a,
                                                     input logic [31:0] b,
                                                     input logic sgn);
    div_pkg::div_result_t r;
    longint sa;
    longint sb;
    longint q;
    longint rm;
    if (b == '0) begin
      // divide by zero: all ones quotient, dividend back as remainder
      r.quot    = '1;
      r.rem     = a;
      r.by_zero = 1'b1;
    end else begin
      if (sgn) begin
        sa = $signed(a);
        sb = $signed(b);
      end else begin
        sa = a;
        sb = b;
      end
      q  = sa / sb;
      rm = sa % sb;
      // most negative by -1 gives 2^31, whose low word is 0x80000000
      r.quot    = q[31:0];
      r.rem     = rm[31:0];
      r.by_zero = 1'b0;
    end
    return r;
  endfunction

  // ----------------------------------------
  // checks and APB driver
  // ----------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // setup, access, then idle; response sampled mid access cycle
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // access edge
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, data, rdata, err);
    check_value("pslverr", err, exp_err);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp,
                             input string name);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    check_value("pslverr", err, 1'b0);
    check_value(name, rdata, exp);
  endtask

  task automatic read_error(input logic [7:0] addr);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    check_value("pslverr", err, 1'b1);
  endtask

  // busy and done bits only
  task automatic flags_expect(input logic [1:0] exp);
    logic [31:0] st;
    logic        err;
    apb_xfer(1'b0, div_pkg::reg_status, '0, st, err);
    check_value("pslverr", err, 1'b0);
    check_value("status busy/done", st[1:0], exp);
  endtask

  // ----------------------------------------
  // division sequences
  // ----------------------------------------

  // returns right after the access edge of the start write
  task automatic start_div(input logic [31:0] a, input logic [31:0] b, input logic sgn);
    write_expect(div_pkg::reg_operand_a, a, 1'b0);
    write_expect(div_pkg::reg_operand_b, b, 1'b0);
    write_expect(div_pkg::reg_ctrl, {30'b0, sgn, 1'b1}, 1'b0);
  endtask

  // poll status, the cycle limit catches a stuck unit
  task automatic wait_done();
    logic [31:0] st;
    logic        err;
    st = '0;
    while (!st[div_pkg::status_done_bit]) begin
      apb_xfer(1'b0, div_pkg::reg_status, '0, st, err);
      check_value("pslverr", err, 1'b0);
    end
  endtask

  task automatic result_expect(input logic [31:0] a, input logic [31:0] b, input logic sgn);
    div_pkg::div_result_t exp;
    exp = model_div(a, b, sgn);
    read_expect(div_pkg::reg_quotient, exp.quot, "quotient");
    read_expect(div_pkg::reg_remainder, exp.rem, "remainder");
    read_expect(div_pkg::reg_status, {29'b0, exp.by_zero, 2'b10}, "status");
  endtask

  task automatic run_div(input logic [31:0] a, input logic [31:0] b, input logic sgn);
    start_div(a, b, sgn);
    wait_done();
    result_expect(a, b, sgn);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pick;
    logic        sgn;
    apb_req <= '0;
    reset   <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // every register reads 0 out of reset
    read_expect(div_pkg::reg_operand_a, '0, "operand_a");
    read_expect(div_pkg::reg_operand_b, '0, "operand_b");
    read_expect(div_pkg::reg_ctrl, '0, "ctrl");
    read_expect(div_pkg::reg_status, '0, "status");
    read_expect(div_pkg::reg_quotient, '0, "quotient");
    read_expect(div_pkg::reg_remainder, '0, "remainder");

    // operand and ctrl readback
    a = next_random();
    b = next_random();
    write_expect(div_pkg::reg_operand_a, a, 1'b0);
    write_expect(div_pkg::reg_operand_b, b, 1'b0);
    read_expect(div_pkg::reg_operand_a, a, "operand_a");
    read_expect(div_pkg::reg_operand_b, b, "operand_b");
    write_expect(div_pkg::reg_ctrl, 32'h2, 1'b0);
    read_expect(div_pkg::reg_ctrl, 32'h2, "ctrl");
    write_expect(div_pkg::reg_ctrl, 32'h0, 1'b0);
    read_expect(div_pkg::reg_ctrl, 32'h0, "ctrl");

    // read-only and unmapped accesses are rejected and change nothing
    write_expect(div_pkg::reg_status, next_random(), 1'b1);
    write_expect(div_pkg::reg_quotient, next_random(), 1'b1);
    write_expect(div_pkg::reg_remainder, next_random(), 1'b1);
    write_expect(8'h18, next_random(), 1'b1);
    write_expect(8'h01, ~a, 1'b1);
    read_error(8'h20);
    read_error(8'hFC);
    read_expect(div_pkg::reg_operand_a, a, "operand_a");
    read_expect(div_pkg::reg_operand_b, b, "operand_b");
    read_expect(div_pkg::reg_status, '0, "status");
    read_expect(div_pkg::reg_quotient, '0, "quotient");
    read_expect(div_pkg::reg_remainder, '0, "remainder");

    // busy right after start
    start_div(32'd1000, 32'd7, 1'b0);
    flags_expect(2'b01);
    wait_done();
    result_expect(32'd1000, 32'd7, 1'b0);
    // sampled in cycle 33 after the start edge, last cycle still running
    start_div(32'hFFFF_FF00, 32'd5, 1'b1);
    repeat (31) @(posedge clk);
    flags_expect(2'b01);
    wait_done();
    result_expect(32'hFFFF_FF00, 32'd5, 1'b1);
    // sampled in cycle 34 after the start edge, first cycle with done
    start_div(32'd12345, 32'd0, 1'b0);
    repeat (32) @(posedge clk);
    flags_expect(2'b10);
    result_expect(32'd12345, 32'd0, 1'b0);

    // second start while busy is rejected, signed bit kept
    start_div(32'h8765_4321, 32'h0000_0123, 1'b1);
    write_expect(div_pkg::reg_ctrl, 32'h1, 1'b1);
    read_expect(div_pkg::reg_ctrl, 32'h2, "ctrl");
    wait_done();
    result_expect(32'h8765_4321, 32'h0000_0123, 1'b1);

    // random divisions with some zero and corner operands
    for (int i = 0; i < num_ops; i++) begin
      a    = next_random();
      b    = next_random();
      pick = next_random();
      sgn  = pick[20];
      case (pick[31:28])
        4'd0: b = '0;
        4'd1: begin
          a   = 32'h8000_0000;
          b   = '1;
          sgn = 1'b1;
        end
        // small divisors and dividends
        4'd2: b = b >> pick[4:0];
        4'd3: a = a >> pick[4:0];
        default: ;
      endcase
      run_div(a, b, sgn);
    end

    // fixed corners, the zero flag clears on the next nonzero division
    run_div(32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
    run_div(32'hDEAD_BEEF, 32'd0, 1'b1);
    run_div(32'hDEAD_BEEF, 32'd3, 1'b0);

    if (dut_i.props_i.fail_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("bound checker saw %0d assertion failures", dut_i.props_i.fail_count);
      abort_run();
    end
  end

endmodule
